//--- src/edge_capture_pkg.sv
`default_nettype none

package edge_capture_pkg;

    // Frame geometry, e.g. 172 x 240 edge pixels
    localparam int FRAME_PIXELS = 41280;
    localparam int FRAME_BYTES  = FRAME_PIXELS / 8;      // Eight edge bits per stored byte
    localparam int ADDR_W       = $clog2(FRAME_BYTES);

    // Write port of the frame store
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
    } store_wr_t;

    // Read port of the frame store
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } store_rd_t;

    // Replayed edge stream, one pixel per cycle
    typedef struct packed {
        logic valid;
        logic pix;                                       // Edge decision of this pixel
        logic last;                                      // Final pixel of the frame
    } pixel_out_t;

endpackage

`default_nettype wire

//--- src/capture_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic arm,
    input  logic read_start,
    input  logic frame_start,
    input  logic frame_done,
    input  logic read_done,
    output logic capture_en,
    output logic read_go,
    output logic captured,
    output logic busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ARMED,
        ST_CAPTURE,
        ST_STORED,
        ST_READ
    } state_t;

    state_t state, state_next;
    logic   read_go_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            read_go <= 1'b0;
        end else begin
            state   <= state_next;
            read_go <= read_go_next;
        end
    end

    always_comb begin
        state_next   = state;
        read_go_next = 1'b0;

        case (state)
            ST_IDLE: begin
                if (arm) begin
                    state_next = ST_ARMED;
                end
            end
            ST_ARMED: begin
                if (frame_start) begin
                    state_next = ST_CAPTURE;              // Capture starts with the next frame
                end
            end
            ST_CAPTURE: begin
                if (frame_done) begin
                    state_next = ST_STORED;
                end
            end
            ST_STORED: begin
                if (read_start) begin
                    state_next   = ST_READ;
                    read_go_next = 1'b1;
                end else if (arm) begin
                    state_next = ST_ARMED;                // Next frame overwrites the stored one
                end
            end
            ST_READ: begin
                if (read_done) begin
                    state_next = ST_STORED;               // Arm is ignored while replaying
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign capture_en = (state == ST_CAPTURE);
    assign captured   = (state == ST_STORED);
    assign busy       = (state == ST_ARMED) || (state == ST_CAPTURE) || (state == ST_READ);

endmodule

`default_nettype wire

//--- src/edge_pack.sv
`timescale 1ns/100ps
`default_nettype none

module edge_pack (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pix_valid,
    input  logic                        pix_edge,
    output edge_capture_pkg::store_wr_t wr,
    output logic                        frame_done
);

    localparam logic [edge_capture_pkg::ADDR_W-1:0] LAST_ADDR =
        edge_capture_pkg::ADDR_W'(edge_capture_pkg::FRAME_BYTES - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_ADVANCE,
        ST_DONE
    } state_t;

    state_t                              state, state_next;
    logic   [2:0]                        bit_cnt, bit_cnt_next;   // Pixel slot within the byte
    logic   [7:0]                        pack_q, pack_next;
    logic   [edge_capture_pkg::ADDR_W-1:0] addr_q, addr_next;
    logic                                wr_en_q, wr_en_next;
    logic                                done_next;
    logic                                take;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            bit_cnt    <= 3'd0;
            addr_q     <= '0;
            wr_en_q    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            state      <= state_next;
            bit_cnt    <= bit_cnt_next;
            addr_q     <= addr_next;
            wr_en_q    <= wr_en_next;
            frame_done <= done_next;
        end
    end

    always_ff @(posedge clk) begin
        pack_q <= pack_next;
    end

    always_comb begin
        state_next   = state;
        bit_cnt_next = bit_cnt;
        pack_next    = pack_q;
        addr_next    = addr_q;
        wr_en_next   = 1'b0;
        done_next    = 1'b0;
        take         = pix_valid && (state != ST_DONE);

        // Pixel k of a byte lands in bit k
        if (take) begin
            pack_next[bit_cnt] = pix_edge;
            bit_cnt_next       = bit_cnt + 3'd1;
        end

        case (state)
            ST_IDLE: begin
                if (take) begin
                    state_next = ST_COLLECT;
                end
            end
            ST_COLLECT: begin
                if (take && (bit_cnt == 3'd7)) begin
                    wr_en_next = 1'b1;                    // Byte complete, write it next cycle
                    state_next = (addr_q == LAST_ADDR) ? ST_DONE : ST_ADVANCE;
                end
            end
            ST_ADVANCE: begin
                addr_next  = addr_q + 1'b1;
                state_next = take ? ST_COLLECT : ST_IDLE;
            end
            ST_DONE: begin
                done_next  = 1'b1;
                addr_next  = '0;                          // Ready for the next capture
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign wr = '{en: wr_en_q, addr: addr_q, data: pack_q};

endmodule

`default_nettype wire

//--- src/frame_store.sv
`timescale 1ns/100ps
`default_nettype none

module frame_store (
    input  logic                        clk,
    input  edge_capture_pkg::store_wr_t wr,
    input  edge_capture_pkg::store_rd_t rd,
    output logic [7:0]                  rd_data
);

    logic [7:0] mem [edge_capture_pkg::FRAME_BYTES];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read data is valid the cycle after the strobe and holds until the next read
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

//--- src/frame_unpack.sv
`timescale 1ns/100ps
`default_nettype none

module frame_unpack (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         read_go,
    output edge_capture_pkg::store_rd_t  rd,
    input  logic [7:0]                   rd_data,
    output edge_capture_pkg::pixel_out_t pix_out,
    output logic                         read_done
);

    logic                                valid_q;
    logic                                first_q;       // Byte 0 is on rd_data this cycle
    logic                                last_byte_q;
    logic [2:0]                          bit_cnt;
    logic [7:0]                          shift_q;
    logic [edge_capture_pkg::ADDR_W-1:0] addr_q;        // Next byte address to fetch
    logic                                more;
    logic                                fetch;
    logic                                load;
    logic                                last_pix;

    assign more = (addr_q != edge_capture_pkg::ADDR_W'(edge_capture_pkg::FRAME_BYTES));

    // Prefetch on slot 6 so the byte is ready when slot 7 shifts out
    assign fetch    = read_go || (valid_q && (bit_cnt == 3'd6) && more);
    assign load     = first_q || (valid_q && (bit_cnt == 3'd7) && !last_byte_q);
    assign last_pix = valid_q && last_byte_q && (bit_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= 1'b0;
            first_q     <= 1'b0;
            last_byte_q <= 1'b0;
            bit_cnt     <= 3'd0;
            addr_q      <= '0;
        end else begin
            first_q <= read_go;

            if (last_pix) begin
                addr_q <= '0;
            end else if (fetch) begin
                addr_q <= addr_q + 1'b1;
            end

            if (load) begin
                valid_q     <= 1'b1;
                bit_cnt     <= 3'd0;
                last_byte_q <= !more;                    // All reads issued, this byte is the final one
            end else if (last_pix) begin
                valid_q     <= 1'b0;
                last_byte_q <= 1'b0;
                bit_cnt     <= 3'd0;
            end else if (valid_q) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= rd_data;
        end else if (valid_q) begin
            shift_q <= {1'b0, shift_q[7:1]};             // Bit 0 goes out first
        end
    end

    assign rd        = '{en: fetch, addr: addr_q};
    assign pix_out   = '{valid: valid_q, pix: shift_q[0], last: last_pix};
    assign read_done = last_pix;

endmodule

`default_nettype wire

//--- src/edge_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module edge_capture_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         frame_start,
    input  logic                         canny_de,
    input  logic [7:0]                   canny_data,
    input  logic                         arm,
    input  logic                         read_start,
    output edge_capture_pkg::pixel_out_t pix_out,
    output logic                         captured,
    output logic                         busy
);

    logic                        capture_en;
    logic                        pix_valid;
    logic                        frame_done;
    logic                        read_go;
    logic                        read_done;
    logic [7:0]                  rd_data;
    edge_capture_pkg::store_wr_t store_wr;
    edge_capture_pkg::store_rd_t store_rd;

    assign pix_valid = canny_de && capture_en;            // Only pixels of the armed frame

    capture_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .arm         (arm),
        .read_start  (read_start),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .read_done   (read_done),
        .capture_en  (capture_en),
        .read_go     (read_go),
        .captured    (captured),
        .busy        (busy)
    );

    edge_pack u_pack (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix_edge   (canny_data[0]),
        .wr         (store_wr),
        .frame_done (frame_done)
    );

    frame_store u_store (
        .clk     (clk),
        .wr      (store_wr),
        .rd      (store_rd),
        .rd_data (rd_data)
    );

    frame_unpack u_unpack (
        .clk       (clk),
        .reset     (reset),
        .read_go   (read_go),
        .rd        (store_rd),
        .rd_data   (rd_data),
        .pix_out   (pix_out),
        .read_done (read_done)
    );

endmodule

`default_nettype wire

//--- verification/edge_capture_sva.sv
`timescale 1ns/100ps
`default_nettype none

module edge_capture_sva (
    input logic                         clk,
    input logic                         reset,
    input logic                         read_go,
    input edge_capture_pkg::pixel_out_t pix_out,
    input logic                         captured,
    input logic                         busy
);

    a_valid_busy: assert property (@(posedge clk) disable iff (reset)
        pix_out.valid |-> busy)
        else $error("pix_out.valid high while busy is low");

    a_status_excl: assert property (@(posedge clk) disable iff (reset)
        !(captured && busy))
        else $error("captured and busy high in the same cycle");

    a_last_captured: assert property (@(posedge clk) disable iff (reset)
        (pix_out.valid && pix_out.last) |=> captured)
        else $error("captured low in the cycle after the last pixel");

    // First pixel two cycles after read_go, then no gap until the last one
    a_stream_start: assert property (@(posedge clk) disable iff (reset)
        read_go |-> ##2 pix_out.valid)
        else $error("no valid pixel two cycles after read_go");

    a_stream_gapless: assert property (@(posedge clk) disable iff (reset)
        (pix_out.valid && !pix_out.last) |=> pix_out.valid)
        else $error("gap in the pixel stream before the last pixel");

endmodule

bind edge_capture_top edge_capture_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .read_go  (read_go),
    .pix_out  (pix_out),
    .captured (captured),
    .busy     (busy)
);

`default_nettype wire

//--- verification/edge_capture_tb.sv
`timescale 1ns/100ps
`default_nettype none

module edge_capture_tb;

    localparam int NUM_FRAMES = 12;                          // Six frames sent and six readouts

    logic                         clk;
    logic                         reset;
    logic                         frame_start;
    logic                         canny_de;
    logic [7:0]                   canny_data;
    logic                         arm;
    logic                         read_start;
    edge_capture_pkg::pixel_out_t pix_out;
    logic                         captured;
    logic                         busy;

    logic [31:0] lfsr;
    logic        frame_bits [edge_capture_pkg::FRAME_PIXELS];
    logic [7:0]  exp_bytes [edge_capture_pkg::FRAME_BYTES];
    logic [7:0]  exp_byte;
    logic        read_active;                                // A readout has been requested
    logic        last_seen;
    int          pix_cnt;
    int          checks;
    int          errors;
    int          test_errors;

    edge_capture_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .canny_de    (canny_de),
        .canny_data  (canny_data),
        .arm         (arm),
        .read_start  (read_start),
        .pix_out     (pix_out),
        .captured    (captured),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Pixel k of group b goes to bit k of expected byte b
    function automatic logic [7:0] pack_byte(input int b);
        logic [7:0] v;
        for (int k = 0; k < 8; k++) begin
            v[k] = frame_bits[8 * b + k];
        end
        return v;
    endfunction

    task automatic next_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    task automatic build_expected();
        for (int b = 0; b < edge_capture_pkg::FRAME_BYTES; b++) begin
            exp_bytes[b] = pack_byte(b);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Sends one frame with random one-cycle gaps and optional arm and read_start pulses
    task automatic send_frame(input int arm_at, input int read_at);
        logic g;
        logic h;
        logic e;
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        for (int i = 0; i < edge_capture_pkg::FRAME_PIXELS; i++) begin
            next_bit(g);
            next_bit(h);
            if (g && h) begin
                @(negedge clk);
            end
            next_bit(e);
            frame_bits[i] = e;
            canny_de      = 1'b1;
            canny_data    = {i[6:0], e};                     // Upper bits are not edge data
            arm           = (i == arm_at);
            read_start    = (i == read_at);
            @(negedge clk);
            canny_de   = 1'b0;
            arm        = 1'b0;
            read_start = 1'b0;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic pulse_arm();
        arm = 1'b1;
        @(negedge clk);
        arm = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_captured();
        int cyc;
        cyc = 0;
        while (!captured && cyc < 20) begin
            @(negedge clk);
            cyc++;
        end
        checks++;
        assert (captured) else begin
            errors++;
            $display("captured did not rise within 20 cycles after the frame");
        end
    endtask

    task automatic do_readout(input int arm_after);
        int cyc;
        pix_cnt     = 0;
        last_seen   = 1'b0;
        read_active = 1'b1;
        read_start  = 1'b1;
        @(negedge clk);
        read_start = 1'b0;
        cyc        = 0;
        while (!last_seen && cyc < edge_capture_pkg::FRAME_PIXELS + 20) begin
            arm = (cyc == arm_after);
            @(negedge clk);
            arm = 1'b0;
            cyc++;
        end
        checks++;
        assert (last_seen) else begin
            errors++;
            $display("Readout did not reach its last pixel");
        end
        checks++;
        assert (pix_cnt == edge_capture_pkg::FRAME_PIXELS) else begin
            errors++;
            $display("** Error: pixel count = 0x%h, expected 0x%h", pix_cnt,
                     edge_capture_pkg::FRAME_PIXELS);
        end
        check_level("captured", captured, 1'b1);             // Back in the stored state
        read_active = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (errors == test_errors) ? "passed" : "failed", errors - test_errors);
        test_errors = errors;
    endtask

    // Compare every valid output pixel with the packed reference frame
    always @(posedge clk) begin
        if (pix_out.valid) begin
            checks += 2;
            assert (read_active && busy && !captured) else begin
                errors++;
                $display("Valid output pixel %0d appeared outside a requested readout", pix_cnt);
            end
            assert (pix_cnt < edge_capture_pkg::FRAME_PIXELS) else begin
                errors++;
                $display("Readout produced more pixels than one frame holds");
            end
            if (read_active && pix_cnt < edge_capture_pkg::FRAME_PIXELS) begin
                checks += 2;
                exp_byte = exp_bytes[pix_cnt / 8];
                assert (pix_out.pix == exp_byte[pix_cnt[2:0]]) else begin
                    errors++;
                    $display("** Error: pix_out.pix = 0x%h, expected 0x%h at pixel %0d",
                             pix_out.pix, exp_byte[pix_cnt[2:0]], pix_cnt);
                end
                assert (pix_out.last == (pix_cnt == edge_capture_pkg::FRAME_PIXELS - 1)) else begin
                    errors++;
                    $display("** Error: pix_out.last = 0x%h, expected 0x%h at pixel %0d",
                             pix_out.last, (pix_cnt == edge_capture_pkg::FRAME_PIXELS - 1),
                             pix_cnt);
                end
            end
            last_seen = last_seen || pix_out.last;
            pix_cnt++;
        end
    end

    initial begin
        repeat (NUM_FRAMES * (edge_capture_pkg::FRAME_PIXELS * 2 + 100)) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        frame_start = 1'b0;
        canny_de    = 1'b0;
        canny_data  = 8'h00;
        arm         = 1'b0;
        read_start  = 1'b0;
        lfsr        = 32'd66433;
        read_active = 1'b0;
        last_seen   = 1'b0;
        pix_cnt     = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_level("captured", captured, 1'b0);
        check_level("busy", busy, 1'b0);
        check_level("pix_out.valid", pix_out.valid, 1'b0);
        send_frame(-1, -1);
        check_level("captured", captured, 1'b0);
        check_level("busy", busy, 1'b0);
        report_test(1, "reset state and unarmed frame");

        pulse_arm();
        check_level("busy", busy, 1'b1);
        send_frame(-1, -1);
        wait_captured();
        build_expected();
        do_readout(-1);
        report_test(2, "capture with gaps and readout");

        send_frame(edge_capture_pkg::FRAME_PIXELS / 2, -1);  // Arm halfway through a frame
        check_level("captured", captured, 1'b0);
        check_level("busy", busy, 1'b1);
        send_frame(-1, -1);
        wait_captured();
        build_expected();
        do_readout(-1);
        report_test(3, "arm in mid frame");

        pulse_arm();
        send_frame(-1, 1000);
        wait_captured();
        build_expected();
        do_readout(-1);
        do_readout(-1);
        report_test(4, "read_start during capture and repeated readout");

        do_readout(1000);
        send_frame(-1, -1);
        check_level("captured", captured, 1'b1);
        check_level("busy", busy, 1'b0);
        do_readout(-1);
        report_test(5, "arm during readout");

        $display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/edge_capture_pkg.sv
src/capture_ctrl.sv
src/edge_pack.sv
src/frame_store.sv
src/frame_unpack.sv
src/edge_capture_top.sv
verification/edge_capture_sva.sv
verification/edge_capture_tb.sv

//--- Makefile
# Verilator build and run for the edge capture testbench

VERILATOR ?= verilator
TOP       ?= edge_capture_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
